/* source/mam_pkg.sv */
package mam_pkg;

   localparam int DATA_WIDTH = 32;          // Must be a multiple of 16
   localparam int ADDR_WIDTH = 32;          // Must be a multiple of 16
   localparam int WORD_FLITS = DATA_WIDTH / 16;
   localparam int ADDR_FLITS = ADDR_WIDTH / 16;

   localparam int MEM_WORDS = 256;
   localparam logic [63:0] MEM_SIZE = 64'(MEM_WORDS * (DATA_WIDTH / 8));  // In bytes
   localparam logic [63:0] BASE_ADDR = 64'h0;                            // Byte address of word 0

   localparam int MAX_PKT_LEN = 8;          // Payload flits per response packet
   localparam int HDR_FLITS = 3;            // dest, src, flags
   localparam int FIFO_DEPTH = 4;

   typedef logic [15:0] flit_data_t;
   typedef logic [DATA_WIDTH-1:0] word_t;
   typedef logic [ADDR_WIDTH-1:0] addr_t;
   typedef logic [13:0] beats_t;
   typedef logic [$clog2(MEM_WORDS)-1:0] mem_idx_t;

   // Packet type in flags[15:14]
   localparam logic [1:0] TYPE_REG = 2'b00;
   localparam logic [1:0] TYPE_EVENT = 2'b10;

   // Register subtype in flags[13:10]
   localparam logic [3:0] SUB_REQ_READ = 4'b0000;
   localparam logic [3:0] SUB_RESP_OK = 4'b1000;
   localparam logic [3:0] SUB_RESP_ERR = 4'b1100;

   localparam flit_data_t MOD_ID = 16'h0003;
   localparam flit_data_t MOD_VERSION = 16'h0000;

   // Register map
   localparam flit_data_t REG_MOD_ID = 16'h0000;
   localparam flit_data_t REG_MOD_VERSION = 16'h0001;
   localparam flit_data_t REG_DATA_WIDTH = 16'h0200;
   localparam flit_data_t REG_ADDR_WIDTH = 16'h0201;
   localparam flit_data_t REG_BASE_ADDR0 = 16'h0202;
   localparam flit_data_t REG_BASE_ADDR1 = 16'h0203;
   localparam flit_data_t REG_BASE_ADDR2 = 16'h0204;
   localparam flit_data_t REG_BASE_ADDR3 = 16'h0205;
   localparam flit_data_t REG_MEM_SIZE0 = 16'h0206;
   localparam flit_data_t REG_MEM_SIZE1 = 16'h0207;
   localparam flit_data_t REG_MEM_SIZE2 = 16'h0208;
   localparam flit_data_t REG_MEM_SIZE3 = 16'h0209;

endpackage

/* source/mam_flit_fifo.sv */
`timescale 1ns/1ps

module mam_flit_fifo
   import mam_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  flit_data_t in_data,
   input  logic       in_valid,
   input  logic       in_last,
   output logic       in_ready,
   output flit_data_t out_data,
   output logic       out_valid,
   output logic       out_last,
   input  logic       out_ready
);

   logic [16:0] entries [FIFO_DEPTH];  // {last, data}
   logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr, rd_ptr;
   logic [$clog2(FIFO_DEPTH):0]   count;
   logic push, pop;

   assign in_ready = count != FIFO_DEPTH;
   assign out_valid = count != 0;
   assign {out_last, out_data} = entries[rd_ptr];
   assign push = in_valid && in_ready;
   assign pop = out_valid && out_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) entries[wr_ptr] <= {in_last, in_data};
   end

endmodule

/* source/mam_memory.sv */
`timescale 1ns/1ps

module mam_memory
   import mam_pkg::*;
(
   input  logic   clk,
   input  logic   rst,
   input  logic   req_valid,
   output logic   req_ready,
   input  logic   req_rw,
   input  addr_t  req_addr,
   input  beats_t req_beats,
   input  logic   write_valid,
   input  word_t  write_data,
   output logic   write_ready,
   output logic   read_valid,
   output word_t  read_data,
   input  logic   read_ready
);

   typedef enum logic [1:0] {M_IDLE, M_WRITE, M_READ} mem_state_t;

   mem_state_t state;
   word_t      mem [MEM_WORDS];
   mem_idx_t   idx, start_idx, next_idx;
   beats_t     left;  // Beats still to go

   assign req_ready = state == M_IDLE;
   assign write_ready = state == M_WRITE;
   assign start_idx = mem_idx_t'((req_addr - addr_t'(BASE_ADDR)) / (DATA_WIDTH / 8) % MEM_WORDS);
   assign next_idx = (idx == mem_idx_t'(MEM_WORDS - 1)) ? '0 : idx + 1'b1;  // Wrap

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= M_IDLE;
         read_valid <= 1'b0;
         idx <= '0;
         left <= '0;
         for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] <= '0;
         end
      end else begin
         case (state)
            M_IDLE: if (req_valid) begin
               idx <= start_idx;
               left <= req_beats;
               if (req_rw) begin
                  state <= M_WRITE;
               end else begin
                  state <= M_READ;
                  read_valid <= 1'b1;
                  read_data <= mem[start_idx];
               end
            end
            M_WRITE: if (write_valid) begin
               mem[idx] <= write_data;
               idx <= next_idx;
               left <= left - 1'b1;
               if (left == beats_t'(1)) state <= M_IDLE;
            end
            M_READ: if (read_ready) begin
               idx <= next_idx;
               left <= left - 1'b1;
               if (left == beats_t'(1)) begin
                  read_valid <= 1'b0;
                  state <= M_IDLE;
               end else begin
                  read_data <= mem[next_idx];  // Next word right behind the accepted one
               end
            end
            default: state <= M_IDLE;
         endcase
      end
   end

endmodule

/* source/mam_regaccess.sv */
`timescale 1ns/1ps

module mam_regaccess
   import mam_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic [9:0] id,
   input  flit_data_t debug_in_data,
   input  logic       debug_in_valid,
   input  logic       debug_in_last,
   output logic       debug_in_ready,
   output flit_data_t debug_out_data,
   output logic       debug_out_valid,
   output logic       debug_out_last,
   input  logic       debug_out_ready,
   output flit_data_t ev_data,
   output logic       ev_valid,
   output logic       ev_last,
   input  logic       ev_ready,
   input  flit_data_t buf_data,
   input  logic       buf_valid,
   input  logic       buf_last,
   output logic       buf_ready
);

   typedef enum logic [2:0] {
      IN_DEST, IN_SRC, IN_FLAGS, IN_REG_ADDR, IN_DROP, IN_EV_DEST, IN_EV_SRC, IN_EV_PASS
   } in_state_t;
   typedef enum logic [1:0] {OUT_IDLE, OUT_REPLY, OUT_BUF} out_state_t;

   in_state_t  in_state;
   out_state_t out_state;
   flit_data_t dest_q, src_q, reg_addr_q, reg_value;
   logic       reg_err, reply_pend;
   logic [1:0] reply_cnt;
   logic       in_xfer, out_xfer, flags_event;

   assign in_xfer = debug_in_valid && debug_in_ready;
   assign out_xfer = debug_out_valid && debug_out_ready;
   assign flags_event = debug_in_data[15:14] == TYPE_EVENT;

   always_comb begin
      debug_in_ready = 1'b0;
      ev_valid = 1'b0;
      ev_data = debug_in_data;
      ev_last = 1'b0;
      case (in_state)
         IN_DEST: debug_in_ready = !reply_pend;  // Held off until the reply is out
         IN_SRC, IN_REG_ADDR, IN_DROP: debug_in_ready = 1'b1;
         IN_FLAGS: debug_in_ready = !flags_event;  // Event flags wait for the replay
         IN_EV_DEST: begin
            ev_valid = 1'b1;
            ev_data = dest_q;
         end
         IN_EV_SRC: begin
            ev_valid = 1'b1;
            ev_data = src_q;
         end
         default: begin
            ev_valid = debug_in_valid;
            ev_last = debug_in_last;
            debug_in_ready = ev_ready;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         in_state <= IN_DEST;
         reply_pend <= 1'b0;
      end else begin
         case (in_state)
            IN_DEST: if (in_xfer) in_state <= IN_SRC;
            IN_SRC: if (in_xfer) in_state <= IN_FLAGS;
            IN_FLAGS: if (debug_in_valid) begin
               if (flags_event) in_state <= IN_EV_DEST;
               else if (debug_in_last) in_state <= IN_DEST;
               else if (debug_in_data[15:14] == TYPE_REG && debug_in_data[13:10] == SUB_REQ_READ)
                  in_state <= IN_REG_ADDR;
               else in_state <= IN_DROP;
            end
            IN_REG_ADDR: if (in_xfer) begin
               reply_pend <= 1'b1;
               in_state <= debug_in_last ? IN_DEST : IN_DROP;
            end
            IN_DROP: if (in_xfer && debug_in_last) in_state <= IN_DEST;
            IN_EV_DEST: if (ev_ready) in_state <= IN_EV_SRC;
            IN_EV_SRC: if (ev_ready) in_state <= IN_EV_PASS;
            IN_EV_PASS: if (in_xfer && debug_in_last) in_state <= IN_DEST;
            default: in_state <= IN_DEST;
         endcase
         if (out_state == OUT_REPLY && out_xfer && debug_out_last) reply_pend <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (in_xfer && in_state == IN_DEST) dest_q <= debug_in_data;
      if (in_xfer && in_state == IN_SRC) src_q <= debug_in_data;
      if (in_xfer && in_state == IN_REG_ADDR) reg_addr_q <= debug_in_data;
   end

   always_comb begin
      reg_err = 1'b0;
      reg_value = '0;
      case (reg_addr_q)
         REG_MOD_ID: reg_value = MOD_ID;
         REG_MOD_VERSION: reg_value = MOD_VERSION;
         REG_DATA_WIDTH: reg_value = flit_data_t'(DATA_WIDTH);
         REG_ADDR_WIDTH: reg_value = flit_data_t'(ADDR_WIDTH);
         REG_BASE_ADDR0: reg_value = BASE_ADDR[15:0];
         REG_BASE_ADDR1: reg_value = BASE_ADDR[31:16];
         REG_BASE_ADDR2: reg_value = BASE_ADDR[47:32];
         REG_BASE_ADDR3: reg_value = BASE_ADDR[63:48];
         REG_MEM_SIZE0: reg_value = MEM_SIZE[15:0];
         REG_MEM_SIZE1: reg_value = MEM_SIZE[31:16];
         REG_MEM_SIZE2: reg_value = MEM_SIZE[47:32];
         REG_MEM_SIZE3: reg_value = MEM_SIZE[63:48];
         default: reg_err = 1'b1;
      endcase
   end

   always_comb begin
      buf_ready = 1'b0;
      debug_out_valid = 1'b0;
      debug_out_data = buf_data;
      debug_out_last = 1'b0;
      case (out_state)
         OUT_REPLY: begin
            debug_out_valid = 1'b1;
            debug_out_last = reply_cnt == 2'd3;
            case (reply_cnt)
               2'd0: debug_out_data = src_q;  // Back to the requester
               2'd1: debug_out_data = flit_data_t'(id);
               2'd2: debug_out_data = {TYPE_REG, reg_err ? SUB_RESP_ERR : SUB_RESP_OK, 10'h0};
               default: debug_out_data = reg_err ? '0 : reg_value;
            endcase
         end
         OUT_BUF: begin
            debug_out_valid = buf_valid;
            debug_out_last = buf_last;
            buf_ready = debug_out_ready;
         end
         default: ;
      endcase
   end

   // Source changes only between packets
   always_ff @(posedge clk) begin
      if (rst) begin
         out_state <= OUT_IDLE;
         reply_cnt <= '0;
      end else begin
         case (out_state)
            OUT_IDLE: begin
               reply_cnt <= '0;
               if (reply_pend) out_state <= OUT_REPLY;
               else if (buf_valid) out_state <= OUT_BUF;
            end
            OUT_REPLY: if (out_xfer) begin
               reply_cnt <= reply_cnt + 2'd1;
               if (debug_out_last) out_state <= OUT_IDLE;
            end
            OUT_BUF: if (out_xfer && debug_out_last) out_state <= OUT_IDLE;
            default: out_state <= OUT_IDLE;
         endcase
      end
   end

endmodule

/* source/mam_engine.sv */
`timescale 1ns/1ps

module mam_engine
   import mam_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic [9:0] id,
   input  flit_data_t ev_data,
   input  logic       ev_valid,
   input  logic       ev_last,
   output logic       ev_ready,
   output flit_data_t rsp_data,
   output logic       rsp_valid,
   output logic       rsp_last,
   input  logic       rsp_ready,
   output logic       req_valid,
   input  logic       req_ready,
   output logic       req_rw,
   output addr_t      req_addr,
   output beats_t     req_beats,
   output logic       write_valid,
   output word_t      write_data,
   input  logic       write_ready,
   input  logic       read_valid,
   input  word_t      read_data,
   output logic       read_ready
);

   typedef enum logic [3:0] {
      E_HDR, E_CMD, E_ADDR, E_REQ,
      E_WR_HDR, E_WR_DATA, E_WR_SEND,
      E_RD_HDR, E_RD_DATA
   } eng_state_t;

   eng_state_t state;

   logic [$clog2(MAX_PKT_LEN)-1:0] flit_cnt;  // Header, address or payload flits
   logic [$clog2(WORD_FLITS)-1:0]  wcnt;      // Flit within a word, may span packets
   logic                           in_pkt;    // Inside an input packet after a word
   logic                           word_end, pkt_full, final_flit;

   assign word_end = wcnt == WORD_FLITS - 1;
   assign pkt_full = flit_cnt == MAX_PKT_LEN - 1;
   assign final_flit = word_end && req_beats == beats_t'(1);

   always_comb begin
      ev_ready = 1'b0;
      rsp_valid = 1'b0;
      rsp_data = '0;
      rsp_last = 1'b0;
      req_valid = 1'b0;
      write_valid = 1'b0;
      read_ready = 1'b0;
      case (state)
         E_HDR, E_CMD, E_ADDR, E_WR_HDR, E_WR_DATA: ev_ready = 1'b1;
         E_REQ: req_valid = 1'b1;
         E_WR_SEND: write_valid = 1'b1;
         E_RD_HDR: begin
            rsp_valid = 1'b1;
            case (flit_cnt)
               0: rsp_data = 16'h0000;  // dest
               1: rsp_data = flit_data_t'(id);
               default: rsp_data = {TYPE_EVENT, 14'h0};
            endcase
         end
         E_RD_DATA: begin
            rsp_valid = read_valid;
            rsp_data = read_data[(WORD_FLITS-1-wcnt)*16 +: 16];  // MSB flit first
            rsp_last = pkt_full || final_flit;
            read_ready = read_valid && rsp_ready && word_end;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= E_HDR;
         flit_cnt <= '0;
         wcnt <= '0;
         in_pkt <= 1'b0;
      end else begin
         case (state)
            E_HDR, E_WR_HDR: if (ev_valid) begin
               flit_cnt <= flit_cnt + 1'b1;
               if (flit_cnt == HDR_FLITS - 1) begin
                  flit_cnt <= '0;
                  state <= (state == E_HDR) ? E_CMD : E_WR_DATA;
               end
            end
            E_CMD: if (ev_valid) state <= E_ADDR;
            E_ADDR: if (ev_valid) begin
               flit_cnt <= flit_cnt + 1'b1;
               if (flit_cnt == ADDR_FLITS - 1) begin
                  flit_cnt <= '0;
                  in_pkt <= !ev_last;  // Write data may follow in this packet
                  state <= E_REQ;
               end
            end
            E_REQ: if (req_ready) begin
               if (!req_rw) state <= E_RD_HDR;
               else state <= in_pkt ? E_WR_DATA : E_WR_HDR;
            end
            E_WR_DATA: if (ev_valid) begin
               if (word_end) begin
                  wcnt <= '0;
                  in_pkt <= !ev_last;
                  state <= E_WR_SEND;
               end else begin
                  wcnt <= wcnt + 1'b1;
                  if (ev_last) state <= E_WR_HDR;
               end
            end
            E_WR_SEND: if (write_ready) begin
               if (req_beats == beats_t'(1)) state <= E_HDR;
               else state <= in_pkt ? E_WR_DATA : E_WR_HDR;
            end
            E_RD_HDR: if (rsp_ready) begin
               flit_cnt <= flit_cnt + 1'b1;
               if (flit_cnt == HDR_FLITS - 1) begin
                  flit_cnt <= '0;
                  state <= E_RD_DATA;
               end
            end
            E_RD_DATA: if (rsp_valid && rsp_ready) begin
               wcnt <= word_end ? '0 : wcnt + 1'b1;
               if (final_flit) begin
                  flit_cnt <= '0;
                  state <= E_HDR;
               end else if (pkt_full) begin
                  flit_cnt <= '0;
                  state <= E_RD_HDR;  // Word may continue in the next packet
               end else begin
                  flit_cnt <= flit_cnt + 1'b1;
               end
            end
            default: state <= E_HDR;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == E_CMD && ev_valid) begin
         req_rw <= ev_data[15];
         req_beats <= ev_data[14] ? ev_data[13:0] : beats_t'(1);  // Single is one beat
      end
      if (state == E_ADDR && ev_valid) req_addr[flit_cnt*16 +: 16] <= ev_data;  // LSB first
      if (state == E_WR_DATA && ev_valid) write_data[(WORD_FLITS-1-wcnt)*16 +: 16] <= ev_data;
      if ((state == E_WR_SEND && write_ready) || read_ready) req_beats <= req_beats - 1'b1;
   end

endmodule

/* source/mam_top.sv */
`timescale 1ns/1ps

module mam_top
   import mam_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic [9:0] id,
   input  flit_data_t debug_in_data,
   input  logic       debug_in_valid,
   input  logic       debug_in_last,
   output logic       debug_in_ready,
   output flit_data_t debug_out_data,
   output logic       debug_out_valid,
   output logic       debug_out_last,
   input  logic       debug_out_ready
);

   flit_data_t ev_data, rsp_data, buf_data;
   logic       ev_valid, ev_last, ev_ready;
   logic       rsp_valid, rsp_last, rsp_ready;
   logic       buf_valid, buf_last, buf_ready;
   logic       req_valid, req_ready, req_rw;
   addr_t      req_addr;
   beats_t     req_beats;
   logic       write_valid, write_ready, read_valid, read_ready;
   word_t      write_data, read_data;

   mam_regaccess i_regaccess (.*);  // Packet sorting and output merge

   mam_engine i_engine (.*);

   mam_flit_fifo i_flit_fifo (
      .clk, .rst,
      .in_data(rsp_data), .in_valid(rsp_valid), .in_last(rsp_last), .in_ready(rsp_ready),
      .out_data(buf_data), .out_valid(buf_valid), .out_last(buf_last), .out_ready(buf_ready)
   );

   mam_memory i_memory (
      .clk, .rst,
      .req_valid, .req_ready, .req_rw, .req_addr, .req_beats,
      .write_valid, .write_data, .write_ready,
      .read_valid, .read_data, .read_ready
   );

endmodule

/* tests/mam_tb.sv */
`timescale 1ns/1ps

module mam_tb
   import mam_pkg::*;
();

   localparam int NUM_OPS = 21;
   localparam int CYCLE_LIMIT = 200 * NUM_OPS + 500;
   localparam logic [1:0] OP_REG = 2'd0;
   localparam logic [1:0] OP_WRITE = 2'd1;
   localparam logic [1:0] OP_READ = 2'd2;
   localparam flit_data_t HOST_SRC = 16'h0040;
   localparam flit_data_t MAM_DEST = 16'h0005;
   localparam flit_data_t EVENT_FLAGS = {TYPE_EVENT, 14'h0};

   typedef struct packed {
      logic [1:0] kind;
      addr_t      addr;
      beats_t     beats;
      logic [1:0] split;      // Input packets that carry a write
      flit_data_t reg_addr;
      flit_data_t reg_value;
      logic       reg_err;
   } op_t;

   logic       clk = 1'b0;
   logic       rst;
   logic [9:0] id;
   flit_data_t debug_in_data, debug_out_data;
   logic       debug_in_valid, debug_in_last, debug_in_ready;
   logic       debug_out_valid, debug_out_last, debug_out_ready;

   op_t         ops [NUM_OPS];
   int          op_cnt;
   word_t       model [MEM_WORDS];
   logic [16:0] exp_q [$];  // {last, data}
   int          errors, rx_count, cycle_count;

   mam_top i_mam_top (.*);

   always #5 clk = ~clk;

   initial begin
      debug_out_ready = 1'b0;
      void'($urandom(32'hc125bde8));
      forever begin
         @(posedge clk);
         #1;
         debug_out_ready = ($urandom % 4) != 0;  // Ready in about 3 of 4 cycles
      end
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < CYCLE_LIMIT) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout: run stopped after %0d cycles with %0d errors", cycle_count, errors);
      $display("Result: FAILED");
      $finish;
   end

   // Output sampled mid-cycle before the transfer edge
   always @(negedge clk) begin
      if (!rst && debug_out_valid && debug_out_ready) begin
         assert (exp_q.size() != 0) else begin
            errors++;
            $display("Output flit %h arrived at %0t with no response pending",
                     debug_out_data, $time);
         end
         if (exp_q.size() != 0) begin
            assert ({debug_out_last, debug_out_data} == exp_q[0]) else begin
               errors++;
               $display("Fail at %0t: flit %0d is %h last %b, expected %h last %b", $time,
                        rx_count, debug_out_data, debug_out_last, exp_q[0][15:0], exp_q[0][16]);
            end
            void'(exp_q.pop_front());
         end
         rx_count++;
      end
   end

   function automatic int word_index(input addr_t addr);
      return int'(((addr - BASE_ADDR[31:0]) >> 2) % MEM_WORDS);
   endfunction

   function automatic word_t write_word(input addr_t addr, input int k);
      return (word_t'(addr) << 8) ^ (32'h9E37_79B9 * word_t'(k + 1));
   endfunction

   function automatic flit_data_t cmd_flit(input logic rw, input beats_t beats);
      if (beats == 1) return {rw, 1'b0, 14'h0};  // Single access
      return {rw, 1'b1, beats};
   endfunction

   // Starts and returns just after a rising edge
   task automatic send_flit(input flit_data_t data, input logic last);
      debug_in_data = data;
      debug_in_valid = 1'b1;
      debug_in_last = last;
      @(negedge clk);
      while (!debug_in_ready) @(negedge clk);
      @(posedge clk);
      #1;
      debug_in_valid = 1'b0;
      debug_in_last = 1'b0;
   endtask

   task automatic send_header(input flit_data_t src, input flit_data_t flags);
      send_flit(MAM_DEST, 1'b0);
      send_flit(src, 1'b0);
      send_flit(flags, 1'b0);
   endtask

   task automatic send_reg_read(input flit_data_t src, input flit_data_t reg_addr);
      send_header(src, {TYPE_REG, SUB_REQ_READ, 10'h0});
      send_flit(reg_addr, 1'b1);
   endtask

   task automatic send_read(input addr_t addr, input beats_t beats);
      send_header(HOST_SRC, EVENT_FLAGS);
      send_flit(cmd_flit(1'b0, beats), 1'b0);
      send_flit(addr[15:0], 1'b0);
      send_flit(addr[31:16], 1'b1);
   endtask

   task automatic send_write(input addr_t addr, input beats_t beats, input int split);
      int total, chunk, in_pkt, n, idx;
      word_t w;
      total = 2 * beats;
      chunk = (split > 1) ? total / split + 1 : total;  // Uneven chunks split words
      idx = word_index(addr);
      send_header(HOST_SRC, EVENT_FLAGS);
      send_flit(cmd_flit(1'b1, beats), 1'b0);
      send_flit(addr[15:0], 1'b0);
      send_flit(addr[31:16], 1'b0);
      in_pkt = 0;
      for (n = 0; n < total; n++) begin
         if (in_pkt == chunk) begin
            send_header(HOST_SRC, EVENT_FLAGS);
            in_pkt = 0;
         end
         w = write_word(addr, n / 2);
         in_pkt++;
         send_flit((n % 2 == 0) ? w[31:16] : w[15:0], (in_pkt == chunk) || (n == total - 1));
      end
      for (n = 0; n < beats; n++) begin
         model[(idx + n) % MEM_WORDS] = write_word(addr, n);
      end
   endtask

   task automatic expect_reg(input flit_data_t src, input flit_data_t value, input logic err);
      exp_q.push_back({1'b0, src});
      exp_q.push_back({1'b0, 6'h0, id});
      exp_q.push_back({1'b0, TYPE_REG, err ? SUB_RESP_ERR : SUB_RESP_OK, 10'h0});
      exp_q.push_back({1'b1, value});
   endtask

   task automatic expect_read(input addr_t addr, input beats_t beats);
      int total, fill, n, idx;
      word_t w;
      logic last;
      total = 2 * beats;
      idx = word_index(addr);
      fill = 0;
      for (n = 0; n < total; n++) begin
         if (fill == 0) begin
            exp_q.push_back({1'b0, 16'h0000});
            exp_q.push_back({1'b0, 6'h0, id});
            exp_q.push_back({1'b0, EVENT_FLAGS});
         end
         w = model[(idx + n / 2) % MEM_WORDS];
         fill++;
         last = (fill == MAX_PKT_LEN) || (n == total - 1);
         exp_q.push_back({last, (n % 2 == 0) ? w[31:16] : w[15:0]});
         if (last) fill = 0;
      end
   endtask

   task automatic add_reg(input flit_data_t reg_addr, input flit_data_t value, input logic err);
      ops[op_cnt] = '0;
      ops[op_cnt].kind = OP_REG;
      ops[op_cnt].reg_addr = reg_addr;
      ops[op_cnt].reg_value = value;
      ops[op_cnt].reg_err = err;
      op_cnt++;
   endtask

   task automatic add_mem(input logic [1:0] kind, input addr_t addr, input beats_t beats,
                          input logic [1:0] split);
      ops[op_cnt] = '0;
      ops[op_cnt].kind = kind;
      ops[op_cnt].addr = addr;
      ops[op_cnt].beats = beats;
      ops[op_cnt].split = split;
      op_cnt++;
   endtask

   task automatic fill_table();
      logic [63:0] mem_bytes;
      mem_bytes = 64'(MEM_WORDS) * 4;
      add_reg(16'h0000, MOD_ID, 1'b0);
      add_reg(16'h0001, MOD_VERSION, 1'b0);
      add_reg(16'h0200, 16'(DATA_WIDTH), 1'b0);
      add_reg(16'h0201, 16'(ADDR_WIDTH), 1'b0);
      add_reg(16'h0202, BASE_ADDR[15:0], 1'b0);
      add_reg(16'h0203, BASE_ADDR[31:16], 1'b0);
      add_reg(16'h0204, BASE_ADDR[47:32], 1'b0);
      add_reg(16'h0205, BASE_ADDR[63:48], 1'b0);
      add_reg(16'h0206, mem_bytes[15:0], 1'b0);
      add_reg(16'h0207, mem_bytes[31:16], 1'b0);
      add_reg(16'h0208, mem_bytes[47:32], 1'b0);
      add_reg(16'h0209, mem_bytes[63:48], 1'b0);
      add_reg(16'h0150, 16'h0000, 1'b1);  // Unmapped
      add_mem(OP_WRITE, 32'h0000_0040, 1, 1);
      add_mem(OP_READ, 32'h0000_0040, 1, 1);
      add_mem(OP_WRITE, 32'h0000_0100, 6, 3);
      add_mem(OP_READ, 32'h0000_0100, 6, 1);  // Packets of 8 and 4 payload flits
      add_mem(OP_WRITE, 32'h0000_03F8, 4, 1);  // Words 254, 255, 0, 1
      add_mem(OP_READ, 32'h0000_03F8, 4, 1);
      add_mem(OP_READ, 32'h0000_03F0, 8, 1);
      add_reg(16'h0200, 16'(DATA_WIDTH), 1'b0);
   endtask

   initial begin
      int i, exp_flits;
      rst = 1'b1;
      id = 10'h2A5;
      debug_in_data = '0;
      debug_in_valid = 1'b0;
      debug_in_last = 1'b0;
      errors = 0;
      rx_count = 0;
      op_cnt = 0;
      for (i = 0; i < MEM_WORDS; i++) model[i] = '0;
      fill_table();
      repeat (4) @(posedge clk);
      #1;
      assert (debug_in_ready && !debug_out_valid) else begin
         errors++;
         $display("Fail at %0t: in_ready %b out_valid %b after reset", $time,
                  debug_in_ready, debug_out_valid);
      end
      rst = 1'b0;
      for (i = 0; i < NUM_OPS; i++) begin
         rx_count = 0;
         exp_flits = 0;
         case (ops[i].kind)
            OP_REG: begin
               expect_reg(HOST_SRC + flit_data_t'(i), ops[i].reg_value, ops[i].reg_err);
               send_reg_read(HOST_SRC + flit_data_t'(i), ops[i].reg_addr);
               exp_flits = HDR_FLITS + 1;
            end
            OP_WRITE: send_write(ops[i].addr, ops[i].beats, ops[i].split);
            default: begin
               expect_read(ops[i].addr, ops[i].beats);
               send_read(ops[i].addr, ops[i].beats);
               exp_flits = HDR_FLITS * ((2 * int'(ops[i].beats) + MAX_PKT_LEN - 1) / MAX_PKT_LEN)
                           + 2 * int'(ops[i].beats);
            end
         endcase
         while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
         end
         repeat (4) @(posedge clk);  // Quiet gap so trailing extra flits are counted
         #1;
         assert (rx_count == exp_flits) else begin
            errors++;
            $display("Fail at %0t: operation %0d gave %0d flits, expected %0d", $time, i,
                     rx_count, exp_flits);
         end
      end
      repeat (20) @(posedge clk);  // Stray flits would show up here
      $display("Finished %0d operations with %0d errors", NUM_OPS, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

/* sources.f */
source/mam_pkg.sv
source/mam_flit_fifo.sv
source/mam_memory.sv
source/mam_regaccess.sv
source/mam_engine.sv
source/mam_top.sv
tests/mam_tb.sv
